//--- design/mtap_dr.sv
// Data register shifter, BYPASS/IDCODE/SELECT/SELECT_OVR registers and falling-edge TDO
module mtap_dr
   import mtap_pkg::*;
   (
   input  logic             tck,
   input  logic             rst_n,
   input  logic             tdi,
   input  tap_ctrl_s        ctrl,
   input  logic [IR_W-1:0]  ir_out,
   input  logic             ir_tdo,
   output logic [SEL_W-1:0] select,
   output logic [SEL_W-1:0] select_ovr,
   output logic             tdo,
   output logic             tdo_en
   );

   // Instruction decode
   logic sel_idcode;
   logic sel_select;
   logic sel_ovr;

   // Shared DR shifter, only the low bits are live for short registers
   logic [DR_W-1:0]     dr_shift;
   logic [DR_W-1:0]     dr_capture;
   logic [DR_W-1:0]     dr_shifted;
   logic [DR_IDX_W-1:0] dr_msb;

   // --------------------------------------------------
   // Register select from the current instruction
   // --------------------------------------------------
   assign sel_idcode = (ir_out == OP_IDCODE);
   assign sel_select = (ir_out == OP_SELECT);
   assign sel_ovr    = (ir_out == OP_SELECT_OVR);

   // Capture value and length of the selected register
   // Anything else behaves as the 1-bit BYPASS
   always_comb
   begin
      dr_capture = '0;
      dr_msb     = '0;
      if (sel_idcode)
      begin
         dr_capture = MTAP_IDCODE;
         dr_msb     = DR_IDX_W'(DR_W - 1);
      end
      else if (sel_select)
      begin
         dr_capture[SEL_W-1:0] = select;
         dr_msb                = DR_IDX_W'(SEL_W - 1);
      end
      else if (sel_ovr)
      begin
         dr_capture[SEL_W-1:0] = select_ovr;
         dr_msb                = DR_IDX_W'(SEL_W - 1);
      end
   end

   // Shift right, TDI enters at the top of the selected length
   always_comb
   begin
      dr_shifted         = {1'b0, dr_shift[DR_W-1:1]};
      dr_shifted[dr_msb] = tdi;
   end

   always_ff @(posedge tck)
   begin
      if (ctrl.capture_dr)
      begin
         dr_shift <= dr_capture;
      end
      else if (ctrl.shift_dr)
      begin
         dr_shift <= dr_shifted;
      end
   end

   // --------------------------------------------------
   // SELECT and SELECT_OVR update registers
   // --------------------------------------------------

   // Cleared by TLR, so every child comes back isolated
   always_ff @(posedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         select     <= '0;
         select_ovr <= '0;
      end
      else if (ctrl.test_logic_reset)
      begin
         select     <= '0;
         select_ovr <= '0;
      end
      else if (ctrl.update_dr)
      begin
         if (sel_select)
         begin
            select <= dr_shift[SEL_W-1:0];
         end
         if (sel_ovr)
         begin
            select_ovr <= dr_shift[SEL_W-1:0];
         end
      end
   end

   // --------------------------------------------------
   // TDO, launched on the falling edge
   // --------------------------------------------------
   always_ff @(negedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tdo    <= 1'b0;
         tdo_en <= 1'b0;
      end
      else
      begin
         tdo_en <= ctrl.shift_any;
         // Hold last bit outside shift states
         if (ctrl.shift_ir)
         begin
            tdo <= ir_tdo;
         end
         else if (ctrl.shift_dr)
         begin
            tdo <= dr_shift[0];
         end
      end
   end

   // Output enable set half a cycle earlier must still match the state
   a_tdo_en_shift: assert property (@(posedge tck) disable iff (!rst_n)
      tdo_en |-> ctrl.shift_any);

endmodule

//--- design/mtap_fsm.sv
// TAP controller state machine, control strobe decode and falling-edge IR-column flag
module mtap_fsm
   import mtap_pkg::*;
   (
   input  logic      tck,
   input  logic      rst_n,
   input  logic      tms,
   output tap_ctrl_s ctrl,
   output logic      selectwir_neg
   );

   tap_state_e state;
   tap_state_e state_nxt;
   logic       in_ir_column;

   // --------------------------------------------------
   // State register and TMS-driven transitions
   // --------------------------------------------------
   always_ff @(posedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= ST_TLR;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   always_comb
   begin
      unique case (state)
         ST_TLR       : state_nxt = tms ? ST_TLR       : ST_RTI;
         ST_RTI       : state_nxt = tms ? ST_SEL_DR    : ST_RTI;
         // DR column
         ST_SEL_DR    : state_nxt = tms ? ST_SEL_IR    : ST_CAPT_DR;
         ST_CAPT_DR   : state_nxt = tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
         ST_SHIFT_DR  : state_nxt = tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
         ST_EXIT1_DR  : state_nxt = tms ? ST_UPDATE_DR : ST_PAUSE_DR;
         ST_PAUSE_DR  : state_nxt = tms ? ST_EXIT2_DR  : ST_PAUSE_DR;
         ST_EXIT2_DR  : state_nxt = tms ? ST_UPDATE_DR : ST_SHIFT_DR;
         ST_UPDATE_DR : state_nxt = tms ? ST_SEL_DR    : ST_RTI;
         // IR column
         ST_SEL_IR    : state_nxt = tms ? ST_TLR       : ST_CAPT_IR;
         ST_CAPT_IR   : state_nxt = tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
         ST_SHIFT_IR  : state_nxt = tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
         ST_EXIT1_IR  : state_nxt = tms ? ST_UPDATE_IR : ST_PAUSE_IR;
         ST_PAUSE_IR  : state_nxt = tms ? ST_EXIT2_IR  : ST_PAUSE_IR;
         ST_EXIT2_IR  : state_nxt = tms ? ST_UPDATE_IR : ST_SHIFT_IR;
         ST_UPDATE_IR : state_nxt = tms ? ST_SEL_DR    : ST_RTI;
         default      : state_nxt = ST_TLR;
      endcase
   end

   // --------------------------------------------------
   // Strobes, all straight from the current state
   // --------------------------------------------------
   assign ctrl.capture_ir       = (state == ST_CAPT_IR);
   assign ctrl.shift_ir         = (state == ST_SHIFT_IR);
   assign ctrl.update_ir        = (state == ST_UPDATE_IR);
   assign ctrl.capture_dr       = (state == ST_CAPT_DR);
   assign ctrl.shift_dr         = (state == ST_SHIFT_DR);
   assign ctrl.update_dr        = (state == ST_UPDATE_DR);
   assign ctrl.test_logic_reset = (state == ST_TLR);
   assign ctrl.shift_any        = ctrl.shift_ir | ctrl.shift_dr;

   // Select-IR-Scan through Update-IR
   assign in_ir_column = (state == ST_SEL_IR)   || (state == ST_CAPT_IR)  ||
                         (state == ST_SHIFT_IR) || (state == ST_EXIT1_IR) ||
                         (state == ST_PAUSE_IR) || (state == ST_EXIT2_IR) ||
                         (state == ST_UPDATE_IR);

   // Sampled mid-cycle so the network sees a glitch-free flag
   // that drops one half cycle after Update-IR is left
   always_ff @(negedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         selectwir_neg <= 1'b0;
      end
      else
      begin
         selectwir_neg <= in_ir_column;
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_one_shift: assert property (@(posedge tck) disable iff (!rst_n)
      $onehot0({ctrl.shift_ir, ctrl.shift_dr}));

endmodule

//--- design/mtap_ir.sv
// Instruction shift register and instruction update register
module mtap_ir
   import mtap_pkg::*;
   (
   input  logic            tck,
   input  logic            rst_n,
   input  logic            tdi,
   input  tap_ctrl_s       ctrl,
   output logic [IR_W-1:0] ir_out,
   output logic            ir_tdo
   );

   // Serial stage, TDI enters at the MSB
   logic [IR_W-1:0] ir_shift;

   // --------------------------------------------------
   // Shift register
   // --------------------------------------------------
   always_ff @(posedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ir_shift <= IR_CAPTURE;
      end
      else if (ctrl.capture_ir)
      begin
         ir_shift <= IR_CAPTURE;
      end
      else if (ctrl.shift_ir)
      begin
         ir_shift <= {tdi, ir_shift[IR_W-1:1]};
      end
   end

   // LSB leaves first
   assign ir_tdo = ir_shift[0];

   // --------------------------------------------------
   // Update register
   // --------------------------------------------------

   // TLR falls back to IDCODE just like rst_n
   always_ff @(posedge tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ir_out <= OP_IDCODE;
      end
      else if (ctrl.test_logic_reset)
      begin
         ir_out <= OP_IDCODE;
      end
      else if (ctrl.update_ir)
      begin
         ir_out <= ir_shift;
      end
   end

   a_idcode_after_tlr: assert property (@(posedge tck) disable iff (!rst_n)
      ctrl.test_logic_reset |=> (ir_out == OP_IDCODE));

endmodule

//--- design/mtap_pkg.sv
// Shared sizes, opcodes, select-mode encoding, TAP state type and control strobe struct
package mtap_pkg;

   // --------------------------------------------------
   // Network and register sizes
   // --------------------------------------------------

   // Child TAPs behind this master
   localparam int NUM_TAPS = 4;
   // Two mode bits per child
   localparam int SEL_W    = 2 * NUM_TAPS;
   localparam int IR_W     = 4;
   // Longest data register is IDCODE, SELECT must fit inside it
   localparam int DR_W     = 32;
   localparam int DR_IDX_W = $clog2(DR_W);

   // --------------------------------------------------
   // Instruction encoding
   // --------------------------------------------------

   // Fixed pattern seen on TDO during an IR scan
   localparam logic [IR_W-1:0] IR_CAPTURE    = 4'b0001;
   localparam logic [IR_W-1:0] OP_IDCODE     = 4'h1;
   localparam logic [IR_W-1:0] OP_SELECT     = 4'h2;
   localparam logic [IR_W-1:0] OP_SELECT_OVR = 4'h3;
   // Unknown opcodes fall back to this one
   localparam logic [IR_W-1:0] OP_BYPASS     = 4'hF;

   // Bit 0 must be set per 1149.1
   localparam logic [DR_W-1:0] MTAP_IDCODE = 32'h1A5E_0013;

   // --------------------------------------------------
   // Per-child select modes, {high, low}
   // --------------------------------------------------
   localparam logic [1:0] MODE_ISOLATED  = 2'b00;
   localparam logic [1:0] MODE_NORMAL    = 2'b01;
   // TDO only while an IR scan is in progress
   localparam logic [1:0] MODE_EXCLUDED  = 2'b10;
   localparam logic [1:0] MODE_DECOUPLED = 2'b11;

   // Standard 1149.1 state encoding
   typedef enum logic [3:0] {
      ST_EXIT2_DR  = 4'h0,
      ST_EXIT1_DR  = 4'h1,
      ST_SHIFT_DR  = 4'h2,
      ST_PAUSE_DR  = 4'h3,
      ST_SEL_IR    = 4'h4,
      ST_UPDATE_DR = 4'h5,
      ST_CAPT_DR   = 4'h6,
      ST_SEL_DR    = 4'h7,
      ST_EXIT2_IR  = 4'h8,
      ST_EXIT1_IR  = 4'h9,
      ST_SHIFT_IR  = 4'hA,
      ST_PAUSE_IR  = 4'hB,
      ST_RTI       = 4'hC,
      ST_UPDATE_IR = 4'hD,
      ST_CAPT_IR   = 4'hE,
      ST_TLR       = 4'hF
   } tap_state_e;

   // One-cycle strobes decoded from the controller state
   typedef struct packed {
      logic capture_ir;
      logic shift_ir;
      logic update_ir;
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
      logic test_logic_reset;
      // Either shift column, qualifies TDO
      logic shift_any;
   } tap_ctrl_s;

endpackage

//--- design/mtap_tapnw.sv
// Per-child enable-TAP and enable-TDO generation from the select and override words
module mtap_tapnw
   import mtap_pkg::*;
   (
   input  logic [SEL_W-1:0]    select,
   input  logic [SEL_W-1:0]    select_ovr,
   input  logic                selectwir_neg,
   output logic [NUM_TAPS-1:0] enabletap,
   output logic [NUM_TAPS-1:0] enabletdo
   );

   // Override can only add mode bits to the written word
   logic [SEL_W-1:0] mode_bits;

   assign mode_bits = select | select_ovr;

   always_comb
   begin
      for (int i = 0; i < NUM_TAPS; i++)
      begin
         // Every mode except isolated has a bit set
         enabletap[i] = mode_bits[2*i] | mode_bits[2*i+1];
         // Low bit alone is normal, high bit alone is excluded
         enabletdo[i] = (mode_bits[2*i] & ~mode_bits[2*i+1]) |
                        (~mode_bits[2*i] & mode_bits[2*i+1] & selectwir_neg);
      end
   end

endmodule

//--- design/mtap_top.sv
// Top level connecting TAP controller, IR, data registers and network control
module mtap_top
   import mtap_pkg::*;
   (
   input  logic                tck,
   input  logic                rst_n,
   input  logic                tms,
   input  logic                tdi,
   output logic                tdo,
   output logic                tdo_en,
   output logic [NUM_TAPS-1:0] enabletap,
   output logic [NUM_TAPS-1:0] enabletdo
   );

   // Controller strobes and IR-column flag
   tap_ctrl_s        ctrl;
   logic             selectwir_neg;
   // Current instruction and IR serial output
   logic [IR_W-1:0]  ir_out;
   logic             ir_tdo;
   // Written select words
   logic [SEL_W-1:0] select;
   logic [SEL_W-1:0] select_ovr;

   mtap_fsm mtap_fsm_i (
      .tck           (tck),
      .rst_n         (rst_n),
      .tms           (tms),
      .ctrl          (ctrl),
      .selectwir_neg (selectwir_neg)
   );

   mtap_ir mtap_ir_i (
      .tck    (tck),
      .rst_n  (rst_n),
      .tdi    (tdi),
      .ctrl   (ctrl),
      .ir_out (ir_out),
      .ir_tdo (ir_tdo)
   );

   mtap_dr mtap_dr_i (
      .tck        (tck),
      .rst_n      (rst_n),
      .tdi        (tdi),
      .ctrl       (ctrl),
      .ir_out     (ir_out),
      .ir_tdo     (ir_tdo),
      .select     (select),
      .select_ovr (select_ovr),
      .tdo        (tdo),
      .tdo_en     (tdo_en)
   );

   mtap_tapnw mtap_tapnw_i (
      .select        (select),
      .select_ovr    (select_ovr),
      .selectwir_neg (selectwir_neg),
      .enabletap     (enabletap),
      .enabletdo     (enabletdo)
   );

endmodule

//--- filelist.f
design/mtap_pkg.sv
design/mtap_fsm.sv
design/mtap_ir.sv
design/mtap_dr.sv
design/mtap_tapnw.sv
design/mtap_top.sv
test/tb_mtap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mTAP testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing \
   --top-module tb_mtap \
   -f filelist.f \
   --Mdir obj_dir

./obj_dir/Vtb_mtap 2>&1 | tee "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
   echo "Simulation failed, see $LOG"
   exit 1
fi

echo "Simulation passed"

//--- test/tb_mtap.sv
// Testbench for the JTAG master TAP with scan tasks, select model, concurrent checks and timeout
module tb_mtap
   import mtap_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   // --------------------------------------------------
   // Run length and timeout budget
   // --------------------------------------------------
   localparam int RESET_CYCLES = 16;
   localparam int N_SEL        = 8;
   localparam int N_OVR        = 4;
   // Upper bound on scans in the whole run, IDCODE scan is the longest
   localparam int NUM_SCANS    = 75;
   localparam int LONG_SCAN    = 40;
   // Twice the worst case as margin
   localparam int MAX_CYCLES   = 2 * NUM_SCANS * LONG_SCAN;

   logic                tck;
   logic                rst_n;
   logic                tms;
   logic                tdi;
   logic                tdo;
   logic                tdo_en;
   logic [NUM_TAPS-1:0] enabletap;
   logic [NUM_TAPS-1:0] enabletdo;

   // Model of the written words and of the IR-scan column
   logic [SEL_W-1:0]    sel_model = '0;
   logic [SEL_W-1:0]    ovr_model = '0;
   logic                wir_model = 1'b0;
   logic [NUM_TAPS-1:0] exp_tap;
   logic [NUM_TAPS-1:0] exp_tdo;

   logic [31:0]         lfsr_state = 32'h6ff17378;
   int                  cycle_count = 0;

   mtap_top mtap_top_i (
      .tck       (tck),
      .rst_n     (rst_n),
      .tms       (tms),
      .tdi       (tdi),
      .tdo       (tdo),
      .tdo_en    (tdo_en),
      .enabletap (enabletap),
      .enabletdo (enabletdo)
   );

   initial
   begin
      tck = 1'b0;
      forever #2 tck = ~tck;
   end

   // --------------------------------------------------
   // Mode rule and checks
   // --------------------------------------------------

   // Any mode other than isolated turns the child TAP on
   function automatic logic [NUM_TAPS-1:0] tap_expect(logic [SEL_W-1:0] s,
                                                      logic [SEL_W-1:0] o);
      logic [SEL_W-1:0]    m;
      logic [NUM_TAPS-1:0] r;
      m = s | o;
      for (int i = 0; i < NUM_TAPS; i++)
      begin
         r[i] = (m[2*i +: 2] != MODE_ISOLATED);
      end
      return r;
   endfunction

   // Normal always drives TDO, excluded only inside the IR column
   function automatic logic [NUM_TAPS-1:0] tdo_expect(logic [SEL_W-1:0] s,
                                                      logic [SEL_W-1:0] o,
                                                      logic             wir);
      logic [SEL_W-1:0]    m;
      logic [NUM_TAPS-1:0] r;
      m = s | o;
      for (int i = 0; i < NUM_TAPS; i++)
      begin
         r[i] = (m[2*i +: 2] == MODE_NORMAL) || ((m[2*i +: 2] == MODE_EXCLUDED) && wir);
      end
      return r;
   endfunction

   assign exp_tap = tap_expect(sel_model, ovr_model);
   assign exp_tdo = tdo_expect(sel_model, ovr_model, wir_model);

   task automatic fail_now(input string msg);
      $display("Fail %0t: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      assert (got === exp)
      else fail_now($sformatf("%s read %h expected %h", what, got, exp));
   endtask

   // Both samples taken on the same edge, models change 1 ns after an edge
   a_enabletap: assert property (@(posedge tck) disable iff (!rst_n)
      enabletap === exp_tap)
      else fail_now($sformatf("enabletap %b expected %b",
                              $sampled(enabletap), $sampled(exp_tap)));

   a_enabletdo: assert property (@(posedge tck) disable iff (!rst_n)
      enabletdo === exp_tdo)
      else fail_now($sformatf("enabletdo %b expected %b",
                              $sampled(enabletdo), $sampled(exp_tdo)));

   // Hang guard
   always @(posedge tck)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("Timeout after %0d TCK cycles, the tests did not finish", cycle_count);
         $display(">>> FAIL");
         $fatal(1, "Timeout");
      end
   end

   // --------------------------------------------------
   // Stimulus helpers
   // --------------------------------------------------

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] r);
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r[i]       = lfsr_state[0];
      end
   endtask

   // One TCK cycle, values sampled on the next rising edge
   // Returns 1 ns after that edge
   task automatic tck_step(input logic tms_v, input logic tdi_v);
      tms = tms_v;
      tdi = tdi_v;
      @(posedge tck);
      #1;
   endtask

   // Starts and ends in Run-Test-Idle
   task automatic goto_reset();
      tck_step(1'b1, 1'b0);
      tck_step(1'b1, 1'b0);
      // Passing through Select-IR-Scan
      wir_model = 1'b1;
      tck_step(1'b1, 1'b0);
      wir_model = 1'b0;
      // First edge seen in Test-Logic-Reset clears SELECT, SELECT_OVR and IR
      tck_step(1'b1, 1'b0);
      sel_model = '0;
      ovr_model = '0;
      tck_step(1'b1, 1'b0);
      tck_step(1'b0, 1'b0);
   endtask

   // Every IR scan must return the fixed capture pattern
   task automatic scan_ir(input logic [IR_W-1:0] op);
      logic [IR_W-1:0] got;
      tck_step(1'b1, 1'b0);
      tck_step(1'b1, 1'b0);
      wir_model = 1'b1;
      tck_step(1'b0, 1'b0);
      tck_step(1'b0, 1'b0);
      // Shift-IR, last bit moves on to Exit1-IR
      for (int i = 0; i < IR_W; i++)
      begin
         tck_step(i == IR_W - 1, op[i]);
         got[i] = tdo;
         assert (tdo_en === 1'b1)
         else fail_now("tdo_en low in a Shift-IR cycle");
      end
      tck_step(1'b1, 1'b0);
      // Opcode takes effect on the edge leaving Update-IR
      tck_step(1'b0, 1'b0);
      wir_model = 1'b0;
      check_value(32'(got), 32'(IR_CAPTURE), "IR capture");
   endtask

   task automatic scan_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
      dout = '0;
      tck_step(1'b1, 1'b0);
      tck_step(1'b0, 1'b0);
      tck_step(1'b0, 1'b0);
      for (int i = 0; i < len; i++)
      begin
         tck_step(i == len - 1, din[i]);
         dout[i] = tdo;
         assert (tdo_en === 1'b1)
         else fail_now("tdo_en low in a Shift-DR cycle");
      end
      tck_step(1'b1, 1'b0);
      tck_step(1'b0, 1'b0);
   endtask

   // Old word comes back on TDO while the new one goes in
   task automatic write_sel_word(input logic to_ovr, input logic [SEL_W-1:0] value);
      logic [31:0]      got;
      logic [SEL_W-1:0] old;
      old = to_ovr ? ovr_model : sel_model;
      scan_dr(32'(value), SEL_W, got);
      check_value(32'(got[SEL_W-1:0]), 32'(old), to_ovr ? "SELECT_OVR" : "SELECT");
      if (to_ovr)
      begin
         ovr_model = value;
      end
      else
      begin
         sel_model = value;
      end
   endtask

   task automatic check_isolated();
      check_value(32'(enabletap), 32'h0, "enabletap after reset");
      check_value(32'(enabletdo), 32'h0, "enabletdo after reset");
      check_value(32'(tdo_en), 32'h0, "tdo_en after reset");
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial
   begin : stimulus
      logic [31:0] got;
      logic [31:0] din;
      rst_n = 1'b0;
      tms   = 1'b1;
      tdi   = 1'b0;
      repeat (RESET_CYCLES) @(posedge tck);
      #1;
      rst_n = 1'b1;
      tck_step(1'b0, 1'b0);

      // IR holds IDCODE straight out of reset
      check_isolated();
      scan_dr(32'h0, 32, got);
      check_value(got, MTAP_IDCODE, "IDCODE after reset");

      // BYPASS and an unknown opcode both give a one-bit delay
      scan_ir(OP_BYPASS);
      take_bits(8, din);
      scan_dr(din, 8, got);
      check_value(got, {24'h0, din[6:0], 1'b0}, "BYPASS");
      scan_ir(4'h7);
      take_bits(8, din);
      scan_dr(din, 8, got);
      check_value(got, {24'h0, din[6:0], 1'b0}, "unknown opcode");

      // Random SELECT words, override zero
      scan_ir(OP_SELECT);
      repeat (N_SEL)
      begin
         take_bits(SEL_W, din);
         write_sel_word(1'b0, din[SEL_W-1:0]);
      end
      write_sel_word(1'b0, sel_model);

      // Override ORed in per child
      repeat (N_OVR)
      begin
         scan_ir(OP_SELECT);
         take_bits(SEL_W, din);
         write_sel_word(1'b0, din[SEL_W-1:0]);
         scan_ir(OP_SELECT_OVR);
         take_bits(SEL_W, din);
         if (din[SEL_W-1:0] == '0)
         begin
            din[0] = 1'b1;
         end
         write_sel_word(1'b1, din[SEL_W-1:0]);
      end

      // All children excluded, TDO only in the IR column
      scan_ir(OP_SELECT_OVR);
      write_sel_word(1'b1, '0);
      scan_ir(OP_SELECT);
      write_sel_word(1'b0, {NUM_TAPS{MODE_EXCLUDED}});
      check_value(32'(enabletap), 32'({NUM_TAPS{1'b1}}), "enabletap excluded");
      check_value(32'(enabletdo), 32'h0, "enabletdo excluded in Run-Test-Idle");
      scan_ir(OP_SELECT);
      write_sel_word(1'b0, sel_model);

      // Nonzero words so the TMS reset has something to clear
      scan_ir(OP_SELECT_OVR);
      take_bits(SEL_W, din);
      write_sel_word(1'b1, din[SEL_W-1:0] | SEL_W'(1));
      goto_reset();
      check_isolated();
      scan_dr(32'h0, 32, got);
      check_value(got, MTAP_IDCODE, "IDCODE after TMS reset");

      $display(">>> PASS");
      $finish;
   end

endmodule
